/* src/soc_bus_pkg.sv */
// System bus definitions
// Wishbone classic request and response words, the address map of the
// on-chip slaves and the default sizes used by the top level.

`default_nettype none

package soc_bus_pkg;

	// master to slave, no burst fields
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
		logic        we;
		logic        cyc;
		logic        stb;
	} wb_m2s_t;

	// slave to master
	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
		logic        err;
	} wb_s2m_t;

	// address map, region is the top address byte
	localparam logic [31:0] RAM_BASE    = 32'h0000_0000;
	localparam logic [31:0] GPIO_BASE   = 32'h0300_0000;
	localparam logic [31:0] REGION_MASK = 32'hff00_0000;

	// default sizes
	localparam int RST_CNT_W_DEF = 14;
	localparam int RAM_WORDS_DEF = 4096;

endpackage

`default_nettype wire

/* src/por_counter.sv */
// Power-on reset counter
// Counts up after the asynchronous reset is released and saturates.
// The all-ones state is the system ready flag.

`default_nettype none

module por_counter #(
	parameter int RST_CNT_W = soc_bus_pkg::RST_CNT_W_DEF
) (
	input  wire  clk,
	input  wire  arst_n_i,
	output logic sys_ready_o
);

	logic [RST_CNT_W-1:0] cnt_q;

	assign sys_ready_o = &cnt_q;

	// stops at all ones
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
		end else if (!sys_ready_o) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// once ready, stays ready until the next reset
	a_ready_sticky: assert property (
		@(posedge clk) disable iff (!arst_n_i) sys_ready_o |=> sys_ready_o
	);

endmodule

`default_nettype wire

/* src/wb_decoder.sv */
// Wishbone address decoder
// Routes the master request to the RAM or the GPIO slave by the region
// byte of the address, muxes the slave responses back and answers
// unmapped accesses, including RAM addresses past the end of the array,
// with a one-cycle registered error. Idle until the system is ready.

`default_nettype none

module wb_decoder #(
	parameter int RAM_WORDS = soc_bus_pkg::RAM_WORDS_DEF
) (
	input  wire                  clk,
	input  wire                  arst_n_i,
	input  wire                  sys_ready_i,
	input  soc_bus_pkg::wb_m2s_t m_req_i,
	output soc_bus_pkg::wb_s2m_t m_rsp_o,
	output soc_bus_pkg::wb_m2s_t ram_req_o,
	input  soc_bus_pkg::wb_s2m_t ram_rsp_i,
	output soc_bus_pkg::wb_m2s_t gpio_req_o,
	input  soc_bus_pkg::wb_s2m_t gpio_rsp_i
);

	import soc_bus_pkg::*;

	// RAM size in bytes, for the in-range check
	localparam logic [31:0] RAM_LIMIT = 32'(RAM_WORDS * 4);

	logic in_ram;
	logic in_gpio;
	logic sel_ram;
	logic sel_gpio;
	logic req_valid;
	logic err_q;

	assign in_ram = ((m_req_i.adr & REGION_MASK) == RAM_BASE) &&
		((m_req_i.adr & ~REGION_MASK) < RAM_LIMIT);
	// single register word, byte offset ignored
	assign in_gpio = (m_req_i.adr & ~32'h3) == GPIO_BASE;

	assign req_valid = sys_ready_i & m_req_i.cyc & m_req_i.stb;
	assign sel_ram   = sys_ready_i & in_ram;
	assign sel_gpio  = sys_ready_i & in_gpio;

	always_comb begin
		ram_req_o      = m_req_i;
		ram_req_o.cyc  = m_req_i.cyc & sel_ram;
		ram_req_o.stb  = m_req_i.stb & sel_ram;
		gpio_req_o     = m_req_i;
		gpio_req_o.cyc = m_req_i.cyc & sel_gpio;
		gpio_req_o.stb = m_req_i.stb & sel_gpio;
	end

	// unmapped access, answered once per request
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= req_valid & ~in_ram & ~in_gpio & ~err_q;
		end
	end

	always_comb begin
		m_rsp_o.dat = '0;
		if (sel_ram) begin
			m_rsp_o.dat = ram_rsp_i.dat;
		end else if (sel_gpio) begin
			m_rsp_o.dat = gpio_rsp_i.dat;
		end
		m_rsp_o.ack = (sel_ram & ram_rsp_i.ack) | (sel_gpio & gpio_rsp_i.ack);
		m_rsp_o.err = err_q | (sel_ram & ram_rsp_i.err) | (sel_gpio & gpio_rsp_i.err);
	end

	a_ack_err_excl: assert property (
		@(posedge clk) disable iff (!arst_n_i) !(m_rsp_o.ack && m_rsp_o.err)
	);

	a_one_slave: assert property (
		@(posedge clk) disable iff (!arst_n_i) $onehot0({ram_req_o.stb, gpio_req_o.stb})
	);

endmodule

`default_nettype wire

/* src/wb_ram.sv */
// On-chip word RAM
// Word-addressed array with byte-lane writes. Read data and ack are
// registered, ack lasts one cycle per request.

`default_nettype none

module wb_ram #(
	parameter int RAM_WORDS = soc_bus_pkg::RAM_WORDS_DEF
) (
	input  wire                  clk,
	input  wire                  arst_n_i,
	input  soc_bus_pkg::wb_m2s_t req_i,
	output soc_bus_pkg::wb_s2m_t rsp_o
);

	import soc_bus_pkg::*;

	localparam int AW = $clog2(RAM_WORDS);

	logic [31:0]   mem [RAM_WORDS];
	logic [31:0]   rdata_q;
	logic [AW-1:0] idx;
	logic          hit;
	logic          ack_q;

	assign idx = req_i.adr[AW+1:2];
	// a held request is served once
	assign hit = req_i.cyc & req_i.stb & ~ack_q;

	always_ff @(posedge clk) begin
		if (hit) begin
			rdata_q <= mem[idx];
			if (req_i.we) begin
				for (int b = 0; b < 4; b++) begin
					if (req_i.sel[b]) begin
						mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;
		end
	end

	assign rsp_o.dat = rdata_q;
	assign rsp_o.ack = ack_q;
	assign rsp_o.err = 1'b0;

	a_ack_after_req: assert property (
		@(posedge clk) disable iff (!arst_n_i) rsp_o.ack |-> $past(req_i.cyc & req_i.stb)
	);

endmodule

`default_nettype wire

/* src/wb_gpio.sv */
// GPIO register
// One bus word. A write uses the high half as a bit mask and the low
// half as the new output values. A read returns the synchronised
// inputs in the high half and the output register in the low half.

`default_nettype none

module wb_gpio (
	input  wire                  clk,
	input  wire                  arst_n_i,
	input  soc_bus_pkg::wb_m2s_t req_i,
	output soc_bus_pkg::wb_s2m_t rsp_o,
	input  wire [15:0]           gpio_i,
	output logic [15:0]          gpio_o
);

	import soc_bus_pkg::*;

	logic [15:0] out_q;
	logic [15:0] sync1_q;
	logic [15:0] sync2_q;
	logic        wr;

	assign wr = req_i.cyc & req_i.stb & req_i.we;

	// only masked bits change
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			out_q <= '0;
		end else if (wr) begin
			out_q <= (out_q & ~req_i.dat[31:16]) | (req_i.dat[15:0] & req_i.dat[31:16]);
		end
	end

	// two-flop input synchroniser
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync1_q <= '0;
			sync2_q <= '0;
		end else begin
			sync1_q <= gpio_i;
			sync2_q <= sync1_q;
		end
	end

	assign gpio_o    = out_q;
	assign rsp_o.dat = {sync2_q, out_q};
	// zero wait state
	assign rsp_o.ack = req_i.cyc & req_i.stb;
	assign rsp_o.err = 1'b0;

endmodule

`default_nettype wire

/* src/soc_bus_top.sv */
// System bus top level
// Power-on reset counter, address decoder, word RAM and GPIO block on a
// single Wishbone classic bus driven by one external master.
// The LED follows GPIO output bit 0, card detect is GPIO input bit 15.

`default_nettype none

module soc_bus_top #(
	parameter int RST_CNT_W = soc_bus_pkg::RST_CNT_W_DEF,
	parameter int RAM_WORDS = soc_bus_pkg::RAM_WORDS_DEF
) (
	input  wire                  clk,
	input  wire                  arst_n_i,
	input  soc_bus_pkg::wb_m2s_t bus_req_i,
	output soc_bus_pkg::wb_s2m_t bus_rsp_o,
	input  wire [14:0]           gpio_i,
	input  wire                  card_detect_i,
	output logic [15:0]          gpio_o,
	output logic                 led_o,
	output logic                 sys_ready_o
);

	import soc_bus_pkg::*;

	wb_m2s_t     ram_req;
	wb_s2m_t     ram_rsp;
	wb_m2s_t     gpio_req;
	wb_s2m_t     gpio_rsp;
	logic        sys_ready;
	logic [15:0] gpio_in;

	assign gpio_in     = {card_detect_i, gpio_i};
	assign led_o       = gpio_o[0];
	assign sys_ready_o = sys_ready;

	por_counter #(
		.RST_CNT_W (RST_CNT_W)
	) i_por (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.sys_ready_o (sys_ready)
	);

	wb_decoder #(
		.RAM_WORDS (RAM_WORDS)
	) i_decoder (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.sys_ready_i (sys_ready),
		.m_req_i     (bus_req_i),
		.m_rsp_o     (bus_rsp_o),
		.ram_req_o   (ram_req),
		.ram_rsp_i   (ram_rsp),
		.gpio_req_o  (gpio_req),
		.gpio_rsp_i  (gpio_rsp)
	);

	wb_ram #(
		.RAM_WORDS (RAM_WORDS)
	) i_ram (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.req_i    (ram_req),
		.rsp_o    (ram_rsp)
	);

	wb_gpio i_gpio (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.req_i    (gpio_req),
		.rsp_o    (gpio_rsp),
		.gpio_i   (gpio_in),
		.gpio_o   (gpio_o)
	);

endmodule

`default_nettype wire

/* tb/tb_soc_bus_top.sv */
// Testbench for the system bus top level
// Drives random Wishbone classic traffic from the master port and checks
// RAM, GPIO and unmapped accesses against a reference model.

`default_nettype none

module tb_soc_bus_top;

	timeunit 1ns;
	timeprecision 1ps;

	import soc_bus_pkg::*;

	localparam int RST_W        = 4;
	localparam int WORDS        = 256;
	localparam int ACCESS_LIMIT = 8;
	localparam int READY_LIMIT  = 2 ** RST_W;
	localparam int N_RAM_WR     = 64;
	localparam int N_GPIO       = 32;
	localparam int N_PINS       = 16;
	localparam int N_UNMAP      = 24;
	localparam int N_MIX        = 300;
	// unmapped accesses count with their two read-backs
	localparam int N_TXN = 1 + WORDS + 2 * N_RAM_WR + 2 * N_GPIO + 2 * N_PINS +
		3 * N_UNMAP + 3 * N_MIX;
	localparam int TIMEOUT_CYCLES = N_TXN * 10 + 100;

	logic        clk = 1'b0;
	logic        arst_n_i;
	wb_m2s_t     bus_req;
	wb_s2m_t     bus_rsp;
	logic [14:0] gpio_i;
	logic        card_detect_i;
	logic [15:0] gpio_o;
	logic        led_o;
	logic        sys_ready_o;

	// reference model
	logic [31:0] ram_model [WORDS];
	logic [15:0] out_model;
	logic [15:0] pin_model;
	int          wr_idx [N_RAM_WR];

	int checks = 0;
	int mismatches = 0;
	int failures = 0;

	always #50 clk = ~clk;

	soc_bus_top #(
		.RST_CNT_W (RST_W),
		.RAM_WORDS (WORDS)
	) i_dut (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.bus_req_i     (bus_req),
		.bus_rsp_o     (bus_rsp),
		.gpio_i        (gpio_i),
		.card_detect_i (card_detect_i),
		.gpio_o        (gpio_o),
		.led_o         (led_o),
		.sys_ready_o   (sys_ready_o)
	);

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s exp %h got %h", name, exp, got);
		end
	endtask

	function automatic logic [31:0] ram_adr(input int idx);
		return RAM_BASE + 32'(idx) * 32'd4;
	endfunction

	function automatic logic [31:0] merge_lanes(input logic [31:0] old,
		input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = dat[8*b +: 8];
			end
		end
		return res;
	endfunction

	// other region, RAM region past the array, or GPIO region off the register
	function automatic logic [31:0] unmapped_adr();
		logic [7:0]  top;
		logic [23:0] off;
		case ($urandom_range(2, 0))
			0: begin
				top = 8'($urandom_range(254, 1));
				if (top >= 8'd3) begin
					top = top + 8'd1;
				end
				off = 24'($urandom);
			end
			1: begin
				top = RAM_BASE[31:24];
				off = 24'(WORDS * 4) + 24'($urandom_range(2 ** 24 - WORDS * 4 - 1, 0));
			end
			default: begin
				top = GPIO_BASE[31:24];
				off = {22'($urandom_range(2 ** 22 - 1, 1)), 2'($urandom)};
			end
		endcase
		return {top, off};
	endfunction

	// one classic cycle, lat counts the cycles before ack or err
	task automatic bus_access(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, input logic we, output logic [31:0] rdata,
		output logic ack, output logic err, output int lat);
		wb_m2s_t req;
		bit      done;
		req     = '0;
		req.adr = adr;
		req.dat = dat;
		req.sel = sel;
		req.we  = we;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		rdata   = '0;
		ack     = 1'b0;
		err     = 1'b0;
		lat     = 0;
		done    = 1'b0;
		@(posedge clk);
		bus_req <= req;
		while (!done) begin
			@(negedge clk);
			if (bus_rsp.ack || bus_rsp.err) begin
				rdata = bus_rsp.dat;
				ack   = bus_rsp.ack;
				err   = bus_rsp.err;
				done  = 1'b1;
			end else if (lat == ACCESS_LIMIT) begin
				failures++;
				$display("no ack or err for access to %h within %0d cycles", adr, lat);
				done = 1'b1;
			end else begin
				lat++;
			end
		end
		@(posedge clk);
		bus_req <= '0;
		// a single response per request
		@(negedge clk);
		compare_value("bus_rsp_o.ack after cycle", 32'h0, 32'(bus_rsp.ack));
		compare_value("bus_rsp_o.err after cycle", 32'h0, 32'(bus_rsp.err));
	endtask

	task automatic ram_write(input int idx, input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] rdata;
		logic        ack;
		logic        err;
		int          lat;
		bus_access(ram_adr(idx), dat, sel, 1'b1, rdata, ack, err, lat);
		compare_value("bus_rsp_o.ack ram write", 32'h1, 32'(ack));
		compare_value("bus_rsp_o.err ram write", 32'h0, 32'(err));
		compare_value("ram write latency", 32'd1, lat);
		ram_model[idx] = merge_lanes(ram_model[idx], dat, sel);
	endtask

	task automatic ram_read(input int idx);
		logic [31:0] rdata;
		logic        ack;
		logic        err;
		int          lat;
		bus_access(ram_adr(idx), $urandom, 4'hf, 1'b0, rdata, ack, err, lat);
		compare_value("bus_rsp_o.ack ram read", 32'h1, 32'(ack));
		compare_value("bus_rsp_o.err ram read", 32'h0, 32'(err));
		compare_value("ram read latency", 32'd1, lat);
		compare_value($sformatf("bus_rsp_o.dat ram[%0d]", idx), ram_model[idx], rdata);
	endtask

	task automatic gpio_write(input logic [15:0] mask, input logic [15:0] val);
		logic [31:0] rdata;
		logic        ack;
		logic        err;
		int          lat;
		bus_access(GPIO_BASE, {mask, val}, 4'hf, 1'b1, rdata, ack, err, lat);
		compare_value("bus_rsp_o.ack gpio write", 32'h1, 32'(ack));
		compare_value("bus_rsp_o.err gpio write", 32'h0, 32'(err));
		compare_value("gpio write latency", 32'd0, lat);
		out_model = (out_model & ~mask) | (val & mask);
		compare_value("gpio_o", 32'(out_model), 32'(gpio_o));
		compare_value("led_o", 32'(out_model[0]), 32'(led_o));
	endtask

	task automatic gpio_read();
		logic [31:0] rdata;
		logic        ack;
		logic        err;
		int          lat;
		bus_access(GPIO_BASE, $urandom, 4'hf, 1'b0, rdata, ack, err, lat);
		compare_value("bus_rsp_o.ack gpio read", 32'h1, 32'(ack));
		compare_value("bus_rsp_o.err gpio read", 32'h0, 32'(err));
		compare_value("gpio read latency", 32'd0, lat);
		compare_value("bus_rsp_o.dat gpio", {pin_model, out_model}, rdata);
	endtask

	task automatic set_pins(input logic [14:0] pins, input logic cd);
		@(posedge clk);
		gpio_i        <= pins;
		card_detect_i <= cd;
		pin_model = {cd, pins};
		// two synchroniser stages and a spare cycle
		repeat (3) @(posedge clk);
	endtask

	task automatic unmapped_access(input logic we);
		logic [31:0] adr;
		logic [31:0] rdata;
		logic        ack;
		logic        err;
		int          lat;
		adr = unmapped_adr();
		bus_access(adr, $urandom, 4'($urandom), we, rdata, ack, err, lat);
		compare_value($sformatf("bus_rsp_o.err at %h", adr), 32'h1, 32'(err));
		compare_value($sformatf("bus_rsp_o.ack at %h", adr), 32'h0, 32'(ack));
		compare_value("unmapped latency", 32'd1, lat);
		// aliased RAM word and GPIO register untouched
		ram_read(int'((adr >> 2) % WORDS));
		gpio_read();
	endtask

	task automatic check_quiet();
		compare_value("bus_rsp_o.ack before ready", 32'h0, 32'(bus_rsp.ack));
		compare_value("bus_rsp_o.err before ready", 32'h0, 32'(bus_rsp.err));
		compare_value("gpio_o before ready", 32'h0, 32'(gpio_o));
		compare_value("led_o before ready", 32'h0, 32'(led_o));
	endtask

	initial begin
		wb_m2s_t early_req;
		int      cycles;
		bit      ready;
		void'($urandom(32'hcd6b));
		arst_n_i      = 1'b0;
		bus_req       = '0;
		gpio_i        = '0;
		card_detect_i = 1'b0;
		out_model     = '0;
		pin_model     = '0;

		repeat (4) @(posedge clk);
		@(negedge clk);
		check_quiet();
		compare_value("sys_ready_o in reset", 32'h0, 32'(sys_ready_o));
		@(posedge clk);
		arst_n_i <= 1'b1;

		// held GPIO write while the counter runs, dropped before ready
		early_req     = '0;
		early_req.adr = GPIO_BASE;
		early_req.dat = 32'hffff_ffff;
		early_req.sel = 4'hf;
		early_req.we  = 1'b1;
		early_req.cyc = 1'b1;
		early_req.stb = 1'b1;
		cycles = 0;
		ready  = 1'b0;
		while (!ready && cycles < READY_LIMIT) begin
			@(posedge clk);
			cycles++;
			if (cycles == 1) begin
				bus_req <= early_req;
			end else if (cycles == 9) begin
				bus_req <= '0;
			end
			@(negedge clk);
			if (sys_ready_o) begin
				ready = 1'b1;
			end else begin
				check_quiet();
			end
		end
		if (!ready) begin
			failures++;
			$display("sys_ready_o still low %0d cycles after reset release", READY_LIMIT);
		end
		@(posedge clk);
		bus_req <= '0;
		@(negedge clk);
		compare_value("gpio_o after early write", 32'h0, 32'(gpio_o));

		for (int i = 0; i < WORDS; i++) begin
			ram_write(i, $urandom, 4'hf);
		end
		for (int i = 0; i < N_RAM_WR; i++) begin
			wr_idx[i] = int'($urandom_range(WORDS - 1, 0));
			ram_write(wr_idx[i], $urandom, 4'($urandom));
		end
		for (int i = 0; i < N_RAM_WR; i++) begin
			ram_read(wr_idx[i]);
		end

		for (int i = 0; i < N_GPIO; i++) begin
			gpio_write(16'($urandom), 16'($urandom));
			gpio_read();
		end
		for (int i = 0; i < N_PINS; i++) begin
			set_pins(15'($urandom), 1'($urandom));
			gpio_read();
		end
		for (int i = 0; i < N_UNMAP; i++) begin
			unmapped_access(1'($urandom));
		end

		for (int i = 0; i < N_MIX; i++) begin
			case ($urandom_range(8, 0))
				0, 1, 2: ram_write(int'($urandom_range(WORDS - 1, 0)), $urandom, 4'($urandom));
				3, 4: ram_read(int'($urandom_range(WORDS - 1, 0)));
				5: gpio_write(16'($urandom), 16'($urandom));
				6: gpio_read();
				7: begin
					set_pins(15'($urandom), 1'($urandom));
					gpio_read();
				end
				default: unmapped_access(1'($urandom));
			endcase
		end

		$display("checks %0d mismatches %0d other errors %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout, test sequence not finished after %0d cycles", TIMEOUT_CYCLES);
		$display("checks %0d mismatches %0d other errors %0d", checks, mismatches, failures);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* soc_bus_top.f */
src/soc_bus_pkg.sv
src/por_counter.sv
src/wb_decoder.sv
src/wb_ram.sv
src/wb_gpio.sv
src/soc_bus_top.sv
tb/tb_soc_bus_top.sv

/* Makefile */
# Verilator build and run of the system bus testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_bus_top
FLIST     ?= soc_bus_top.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# pass only if the pass line is printed
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)
